// ==== Bender.yml ====
package:
  name: blitter

sources:
  - include_dirs:
      - src
    files:
      - src/blit_pkg.sv
      - src/blit_regs.sv
      - src/blit_sequencer.sv
      - src/blit_datapath.sv
      - src/blitter.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/blitter_assert.sv
      - verification/blitter_tb.sv

// ==== blitter.f ====
+incdir+src
src/blit_pkg.sv
src/blit_regs.sv
src/blit_sequencer.sv
src/blit_datapath.sv
src/blitter.sv
verification/blitter_assert.sv
verification/blitter_tb.sv

// ==== src/blit_datapath.sv ====
// blitter write-data path
// nibble shifter for B reads, A AND B XOR C logic operation,
// transparency test and nibble write mask

`timescale 1ns/100ps

`include "blit_params.svh"

module blit_datapath
    import blit_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_i,
    input  blit_job_t               job_i,
    input  word_t                   vram_data_i,
    input  logic                    load_i,         // job start
    input  logic                    line_start_i,
    input  logic                    b_take_i,       // B read data valid
    input  logic                    first_word_i,
    input  logic                    last_word_i,
    output word_t                   wr_data_o,
    output logic [`BLIT_NIB-1:0]    wr_mask_o
);

    localparam int SPILL_W = `BLIT_DATA_W - 4;

    blit_ctrl_t             ctrl;
    blit_shift_t            shift;
    word_t                  val_a;
    word_t                  val_b;
    word_t                  val_c;
    word_t                  val_t;                  // B XOR TT, zero where transparent
    word_t                  tt;
    logic [SPILL_W-1:0]     spill;
    logic [`BLIT_DATA_W+SPILL_W-1:0] shift_wide;
    word_t                  shift_word;
    logic [`BLIT_NIB-1:0]   transp_nib;

    assign tt = {ctrl.transp_t, ctrl.transp_t};

    // spill nibbles from the previous word fill the top of this one
    assign shift_wide = {vram_data_i, {SPILL_W{1'b0}}} >> {shift.count, 2'b00};
    assign shift_word = shift_wide[`BLIT_DATA_W+SPILL_W-1:SPILL_W] | {spill, 4'b0000};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ctrl  <= '0;
            shift <= '0;
            val_t <= '0;
        end else if (load_i) begin
            ctrl  <= job_i.ctrl;
            shift <= job_i.shift;
            val_a <= job_i.src_a;
            val_b <= job_i.src_b;               // constant B is used as written
            val_c <= job_i.val_c;
            val_t <= job_i.src_b ^ {job_i.ctrl.transp_t, job_i.ctrl.transp_t};
        end else if (line_start_i) begin
            spill <= '0;
        end else if (b_take_i) begin
            val_b <= ctrl.b_not ? ~shift_word : shift_word;
            val_t <= shift_word ^ tt;
            spill <= shift_wide[SPILL_W-1:0];
            if (ctrl.c_use_b) begin
                val_c <= shift_word;
            end
        end
    end

    always_comb begin
        if (ctrl.transp_8b) begin
            transp_nib = {{2{|val_t[15:8]}}, {2{|val_t[7:0]}}};
        end else begin
            transp_nib = {|val_t[15:12], |val_t[11:8], |val_t[7:4], |val_t[3:0]};
        end
    end

    assign wr_data_o = (val_a & val_b) ^ val_c;
    assign wr_mask_o = (first_word_i ? shift.l_mask : {`BLIT_NIB{1'b1}})
                     & (last_word_i ? shift.r_mask : {`BLIT_NIB{1'b1}})
                     & transp_nib;

endmodule

// ==== src/blit_params.svh ====
// blitter widths and register numbers
// register numbers follow the host register map, with gaps left unused

`ifndef BLIT_PARAMS_SVH
`define BLIT_PARAMS_SVH

`define BLIT_DATA_W     16              // vram and register word
`define BLIT_ADDR_W     16              // vram address
`define BLIT_LINES_W    15              // line count, stored minus one
`define BLIT_NIB        4               // nibbles per word, write mask width
`define BLIT_T_W        8               // transparency byte
`define BLIT_SHIFT_W    2               // nibble shift count

`define BLIT_REG_CTRL   4'd0
`define BLIT_REG_SHIFT  4'd1
`define BLIT_REG_MOD_B  4'd3
`define BLIT_REG_MOD_D  4'd5
`define BLIT_REG_SRC_A  4'd6
`define BLIT_REG_SRC_B  4'd7
`define BLIT_REG_VAL_C  4'd8
`define BLIT_REG_DST_D  4'd9
`define BLIT_REG_LINES  4'd10
`define BLIT_REG_WORDS  4'd11

`endif

// ==== src/blit_pkg.sv ====
// blitter types: data and address words, control and shift fields,
// the register word union, the job snapshot and the sequencer states

`include "blit_params.svh"

package blit_pkg;

    typedef logic [`BLIT_DATA_W-1:0] word_t;
    typedef logic [`BLIT_ADDR_W-1:0] addr_t;

    typedef struct packed {
        logic [`BLIT_T_W-1:0]   transp_t;   // transparency byte
        logic [1:0]             unused;
        logic                   transp_8b;  // 8-bit transparency test
        logic                   reserved;
        logic                   c_use_b;    // C replaced by shifted B
        logic                   b_not;      // invert B read from vram
        logic                   b_const;    // B is src_b, no reads
        logic                   a_const;    // A is always constant here
    } blit_ctrl_t;

    typedef struct packed {
        logic [`BLIT_NIB-1:0]       l_mask;     // first word of line
        logic [`BLIT_NIB-1:0]       r_mask;     // last word of line
        logic [5:0]                 unused;
        logic [`BLIT_SHIFT_W-1:0]   count;      // right shift in nibbles
    } blit_shift_t;

    // one host data word, seen as raw data, control or shift fields
    typedef union packed {
        word_t          word;
        blit_ctrl_t     ctrl;
        blit_shift_t    shift;
    } blit_reg_word_u;

    typedef struct packed {
        blit_ctrl_t                 ctrl;
        blit_shift_t                shift;
        word_t                      mod_b;
        word_t                      mod_d;
        word_t                      src_a;      // constant A value
        addr_t                      src_b;      // B address, or B constant
        word_t                      val_c;
        addr_t                      dst_d;
        logic [`BLIT_LINES_W-1:0]   lines;      // lines minus one
        word_t                      words;      // words per line minus one
    } blit_job_t;

    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        LINE_BEG,
        WAIT_RD_B,
        WAIT_WR_D,
        LINE_END
    } blit_state_t;

endpackage

// ==== src/blit_regs.sv ====
// host register file of the blitter
// collects one pending job and holds it queued until the sequencer takes it

`timescale 1ns/100ps

`include "blit_params.svh"

module blit_regs
    import blit_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  logic            reg_wr_i,       // one-cycle write strobe
    input  logic [3:0]      reg_num_i,
    input  blit_reg_word_u  reg_data_i,
    input  logic            take_i,         // job copied by the sequencer
    output blit_job_t       job_o,
    output logic            queued_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            job_o    <= '0;
            queued_o <= 1'b0;
        end else begin
            if (take_i) begin
                queued_o <= 1'b0;
            end

            // a words write in the take cycle queues the next job
            if (reg_wr_i) begin
                case (reg_num_i)
                    `BLIT_REG_CTRL: begin
                        job_o.ctrl  <= reg_data_i.ctrl;
                    end
                    `BLIT_REG_SHIFT: begin
                        job_o.shift <= reg_data_i.shift;
                    end
                    `BLIT_REG_MOD_B: begin
                        job_o.mod_b <= reg_data_i.word;
                    end
                    `BLIT_REG_MOD_D: begin
                        job_o.mod_d <= reg_data_i.word;
                    end
                    `BLIT_REG_SRC_A: begin
                        job_o.src_a <= reg_data_i.word;
                    end
                    `BLIT_REG_SRC_B: begin
                        job_o.src_b <= reg_data_i.word;
                    end
                    `BLIT_REG_VAL_C: begin
                        job_o.val_c <= reg_data_i.word;
                    end
                    `BLIT_REG_DST_D: begin
                        job_o.dst_d <= reg_data_i.word;
                    end
                    `BLIT_REG_LINES: begin
                        job_o.lines <= reg_data_i.word[`BLIT_LINES_W-1:0];
                    end
                    `BLIT_REG_WORDS: begin
                        job_o.words <= reg_data_i.word;
                        queued_o    <= 1'b1;    // job complete, ready to run
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// ==== src/blit_sequencer.sv ====
// blitter job sequencer
// walks lines and words of a job, issues vram reads of B and writes of D,
// steps the addresses and reports busy and done

`timescale 1ns/100ps

`include "blit_params.svh"

module blit_sequencer
    import blit_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  blit_job_t   job_i,
    input  logic        queued_i,
    output logic        take_o,
    input  logic        vram_ack_i,
    output logic        vram_sel_o,
    output logic        vram_wr_o,
    output addr_t       vram_addr_o,
    output logic        load_o,
    output logic        line_start_o,
    output logic        b_take_o,
    output logic        first_word_o,
    output logic        last_word_o,
    output logic        busy_o,
    output logic        done_o
);

    blit_state_t                state;
    addr_t                      src_b;
    addr_t                      dst_d;
    word_t                      mod_b;
    word_t                      mod_d;
    logic                       b_const;
    word_t                      words;
    logic [`BLIT_LINES_W:0]     lines;      // msb set on underflow
    logic [`BLIT_DATA_W:0]      count;      // msb set on underflow

    assign busy_o       = (state != IDLE);
    assign take_o       = (state == SETUP);
    assign load_o       = (state == SETUP);
    assign line_start_o = (state == LINE_BEG);
    assign b_take_o     = (state == WAIT_RD_B) && vram_ack_i;
    assign last_word_o  = count[`BLIT_DATA_W];

    // both counts are stored minus one, so underflow marks the last pass
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state        <= IDLE;
            vram_sel_o   <= 1'b0;
            vram_wr_o    <= 1'b0;
            vram_addr_o  <= '0;
            done_o       <= 1'b0;
            first_word_o <= 1'b0;
            lines        <= '0;
            count        <= '0;
        end else begin
            done_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (queued_i) begin
                        state <= SETUP;
                    end
                end
                SETUP: begin
                    src_b   <= job_i.src_b;
                    dst_d   <= job_i.dst_d;
                    mod_b   <= job_i.mod_b;
                    mod_d   <= job_i.mod_d;
                    b_const <= job_i.ctrl.b_const;
                    words   <= job_i.words;
                    lines   <= {1'b0, job_i.lines};
                    state   <= LINE_BEG;
                end
                LINE_BEG: begin
                    lines        <= lines - 1'b1;
                    count        <= {1'b0, words} - 1'b1;
                    first_word_o <= 1'b1;
                    vram_sel_o   <= 1'b1;
                    if (!b_const) begin
                        vram_wr_o   <= 1'b0;        // read B first
                        vram_addr_o <= src_b;
                        state       <= WAIT_RD_B;
                    end else begin
                        vram_wr_o   <= 1'b1;
                        vram_addr_o <= dst_d;
                        state       <= WAIT_WR_D;
                    end
                end
                WAIT_RD_B: begin
                    if (vram_ack_i) begin
                        src_b       <= src_b + 1'b1;
                        vram_wr_o   <= 1'b1;        // now write D
                        vram_addr_o <= dst_d;
                        state       <= WAIT_WR_D;
                    end
                end
                WAIT_WR_D: begin
                    if (vram_ack_i) begin
                        dst_d        <= dst_d + 1'b1;
                        count        <= count - 1'b1;
                        first_word_o <= 1'b0;
                        if (last_word_o) begin
                            vram_sel_o <= 1'b0;
                            vram_wr_o  <= 1'b0;
                            state      <= LINE_END;
                        end else if (!b_const) begin
                            vram_wr_o   <= 1'b0;
                            vram_addr_o <= src_b;
                            state       <= WAIT_RD_B;
                        end else begin
                            vram_addr_o <= dst_d + 1'b1;    // next constant write
                        end
                    end
                end
                LINE_END: begin
                    src_b <= src_b + mod_b;
                    dst_d <= dst_d + mod_d;
                    if (lines[`BLIT_LINES_W]) begin
                        done_o <= 1'b1;
                        state  <= queued_i ? SETUP : IDLE;
                    end else begin
                        state <= LINE_BEG;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== src/blitter.sv ====
// blitter top level
// job register file, job sequencer and write-data path

`timescale 1ns/100ps

`include "blit_params.svh"

module blitter
    import blit_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    reg_wr_i,
    input  logic [3:0]              reg_num_i,
    input  word_t                   reg_data_i,
    output logic                    busy_o,
    output logic                    full_o,         // a job is queued
    output logic                    done_o,
    output logic                    vram_sel_o,
    input  logic                    vram_ack_i,
    output logic                    vram_wr_o,
    output addr_t                   vram_addr_o,
    output logic [`BLIT_NIB-1:0]    vram_mask_o,
    input  word_t                   vram_data_i,
    output word_t                   vram_data_o
);

    blit_job_t  job;
    logic       take;
    logic       load;
    logic       line_start;
    logic       b_take;
    logic       first_word;
    logic       last_word;

    blit_regs u_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .reg_wr_i   (reg_wr_i),
        .reg_num_i  (reg_num_i),
        .reg_data_i (reg_data_i),
        .take_i     (take),
        .job_o      (job),
        .queued_o   (full_o)
    );

    blit_sequencer u_sequencer (
        .clk            (clk),
        .reset_i        (reset_i),
        .job_i          (job),
        .queued_i       (full_o),
        .take_o         (take),
        .vram_ack_i     (vram_ack_i),
        .vram_sel_o     (vram_sel_o),
        .vram_wr_o      (vram_wr_o),
        .vram_addr_o    (vram_addr_o),
        .load_o         (load),
        .line_start_o   (line_start),
        .b_take_o       (b_take),
        .first_word_o   (first_word),
        .last_word_o    (last_word),
        .busy_o         (busy_o),
        .done_o         (done_o)
    );

    blit_datapath u_datapath (
        .clk            (clk),
        .reset_i        (reset_i),
        .job_i          (job),
        .vram_data_i    (vram_data_i),
        .load_i         (load),
        .line_start_i   (line_start),
        .b_take_i       (b_take),
        .first_word_i   (first_word),
        .last_word_i    (last_word),
        .wr_data_o      (vram_data_o),
        .wr_mask_o      (vram_mask_o)
    );

endmodule

// ==== verification/blitter_assert.sv ====
// concurrent checks bound to the blitter top level:
// vram request hold, single-cycle done, no select rise while idle

`timescale 1ns/100ps

`include "blit_params.svh"

module blitter_assert (
    input logic                     clk,
    input logic                     reset_i,
    input logic                     vram_sel_o,
    input logic                     vram_wr_o,
    input logic                     vram_ack_i,
    input logic [`BLIT_ADDR_W-1:0]  vram_addr_o,
    input logic                     busy_o,
    input logic                     done_o
);

    // a pending request keeps address and direction until acknowledged
    req_hold: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o && !vram_ack_i |=> vram_sel_o && $stable(vram_addr_o) && $stable(vram_wr_o))
        else $error("vram request changed before its acknowledge");

    done_pulse: assert property (@(posedge clk) disable iff (reset_i) done_o |=> !done_o)
        else $error("done stayed high for more than one cycle");

    sel_idle: assert property (@(posedge clk) disable iff (reset_i)
        $rose(vram_sel_o) |-> $past(busy_o))     // select only rises after a job left idle
        else $error("vram select rose while the sequencer was idle");

endmodule

bind blitter blitter_assert u_assert (.*);

// ==== verification/blitter_tb.sv ====
// testbench of the blitter
// random jobs, vram model with random wait states, done counter,
// reference model on a copy of the memory and full memory compare

`timescale 1ns/100ps

`include "blit_params.svh"

module blitter_tb;

    typedef struct packed {
        logic [7:0]     t;          // transparency byte
        logic           t8;
        logic           c_use_b;
        logic           b_not;
        logic           b_const;
        logic [3:0]     l_mask;
        logic [3:0]     r_mask;
        logic [1:0]     shift;
        logic [15:0]    mod_b;
        logic [15:0]    mod_d;
        logic [15:0]    a;
        logic [15:0]    b;          // B address or B constant
        logic [15:0]    c;
        logic [15:0]    d;
        logic [14:0]    lines;      // minus one
        logic [15:0]    words;      // minus one
    } job_rec_t;

    logic           clk;
    logic           reset_i;
    logic           reg_wr_i;
    logic [3:0]     reg_num_i;
    logic [15:0]    reg_data_i;
    logic           busy_o;
    logic           full_o;
    logic           done_o;
    logic           vram_sel_o;
    logic           vram_ack_i;
    logic           vram_wr_o;
    logic [15:0]    vram_addr_o;
    logic [3:0]     vram_mask_o;
    logic [15:0]    vram_data_i;
    logic [15:0]    vram_data_o;

    logic [15:0]    vram [4096];
    logic [15:0]    model [4096];       // expected memory contents
    job_rec_t       jobs [10];
    string          test_name [10];
    integer         seed = 99;
    integer         wait_cnt = 0;
    integer         done_cnt = 0;
    integer         error_count = 0;
    integer         timeout_ns = 0;
    logic           full_mask_check = 1'b0;

    blitter u_blitter (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run;
        error_count = error_count + 1;
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic [15:0] merge(input logic [15:0] old_w, input logic [15:0] new_w,
                                          input logic [3:0] mask);
        logic [15:0] res;
        int n;
        res = old_w;
        for (n = 0; n < 4; n++) begin
            if (mask[n]) begin
                res[4*n +: 4] = new_w[4*n +: 4];
            end
        end
        return res;
    endfunction

    always @(posedge clk) begin
        if (done_o === 1'b1) begin
            done_cnt <= done_cnt + 1;
        end
    end

    // vram: 0 to 3 wait cycles, then a one-cycle acknowledge
    always @(negedge clk) begin
        if (reset_i) begin
            vram_ack_i <= 1'b0;
            wait_cnt   <= 0;
        end else if (vram_ack_i) begin
            vram_ack_i <= 1'b0;
            wait_cnt   <= $random(seed) & 3;
        end else if (vram_sel_o) begin
            if (wait_cnt == 0) begin
                vram_ack_i <= 1'b1;
                if (vram_wr_o) begin
                    vram[vram_addr_o[11:0]] <= merge(vram[vram_addr_o[11:0]], vram_data_o,
                                                     vram_mask_o);
                    assert (!full_mask_check || vram_mask_o == 4'hf) else begin
                        $display("Mismatch const_fill mask: expected f, actual %h", vram_mask_o);
                        fail_run();
                    end
                end else begin
                    vram_data_i <= vram[vram_addr_o[11:0]];
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    function automatic job_rec_t gen_job(input int kind);
        job_rec_t j;
        j.t8      = $random(seed);
        j.c_use_b = $random(seed);
        j.b_not   = $random(seed);
        j.b_const = $random(seed);
        j.l_mask  = $random(seed);
        j.r_mask  = $random(seed);
        j.shift   = $random(seed);
        j.a       = $random(seed);
        j.b       = $random(seed);
        j.c       = $random(seed);
        j.d       = $random(seed);
        j.mod_b   = $random(seed) & 15;
        j.mod_d   = $random(seed) & 15;
        j.lines   = $random(seed) & 3;
        j.words   = $random(seed) & 7;
        j.t       = $random(seed);
        if (kind == 0) begin                    // constant fill, every nibble written
            j.b_const = 1'b1;
            j.l_mask  = 4'hf;
            j.r_mask  = 4'hf;
            j.t       = 8'h00;
            j.b       = j.b | 16'h1111;
        end else if (kind != 2) begin
            j.b_const = 1'b0;
        end
        if (kind == 1) begin                    // plain shifted copy
            j.t       = 8'h00;
            j.b_not   = 1'b0;
            j.c_use_b = 1'b0;
        end else if (kind == 3) begin           // long enough to queue behind
            j.lines = j.lines + 3;
            j.words = j.words + 3;
        end
        return j;
    endfunction

    task automatic write_reg(input logic [3:0] num, input logic [15:0] data);
        @(negedge clk);
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
    endtask

    task automatic load_job(input job_rec_t j);
        write_reg(`BLIT_REG_CTRL, {j.t, 2'b00, j.t8, 1'b0, j.c_use_b, j.b_not, j.b_const, 1'b1});
        write_reg(`BLIT_REG_SHIFT, {j.l_mask, j.r_mask, 6'd0, j.shift});
        write_reg(`BLIT_REG_MOD_B, j.mod_b);
        write_reg(`BLIT_REG_MOD_D, j.mod_d);
        write_reg(`BLIT_REG_SRC_A, j.a);
        write_reg(`BLIT_REG_SRC_B, j.b);
        write_reg(`BLIT_REG_VAL_C, j.c);
        write_reg(`BLIT_REG_DST_D, j.d);
        write_reg(`BLIT_REG_LINES, {1'b0, j.lines});
        write_reg(`BLIT_REG_WORDS, j.words);    // queues the job
        @(negedge clk);
        reg_wr_i = 1'b0;
    endtask

    // word by word: B with per-line spill, A AND B XOR C, edge and transparency mask
    task automatic apply_model(input job_rec_t j);
        logic [15:0] src;
        logic [15:0] dst;
        logic [15:0] prev;
        logic [15:0] bs;
        logic [15:0] b_val;
        logic [15:0] c_val;
        logic [15:0] tv;
        logic [3:0]  mask;
        int ln;
        int wd;
        int n;
        src   = j.b;
        dst   = j.d;
        c_val = j.c;
        for (ln = 0; ln <= j.lines; ln++) begin
            prev = 16'h0000;
            for (wd = 0; wd <= j.words; wd++) begin
                if (j.b_const) begin
                    b_val = j.b;
                    tv    = j.b;
                end else begin
                    bs    = {prev, model[src[11:0]]} >> (4 * j.shift);
                    prev  = model[src[11:0]];
                    src   = src + 1;
                    tv    = bs;
                    b_val = j.b_not ? ~bs : bs;
                    if (j.c_use_b) begin
                        c_val = bs;
                    end
                end
                tv = tv ^ {j.t, j.t};
                for (n = 0; n < 4; n++) begin
                    mask[n] = j.t8 ? (tv[8*(n/2) +: 8] != 0) : (tv[4*n +: 4] != 0);
                end
                if (wd == 0) begin
                    mask = mask & j.l_mask;
                end
                if (wd == j.words) begin
                    mask = mask & j.r_mask;
                end
                model[dst[11:0]] = merge(model[dst[11:0]], (j.a & b_val) ^ c_val, mask);
                dst = dst + 1;
            end
            src = src + j.mod_b;
            dst = dst + j.mod_d;
        end
    endtask

    task automatic compare_mem(input string name);
        int i;
        for (i = 0; i < 4096; i++) begin
            assert (vram[i] === model[i]) else begin
                $display("Mismatch %s at %03h: expected %04h, actual %04h",
                         name, i, model[i], vram[i]);
                fail_run();
            end
        end
    endtask

    task automatic check_idle;
        assert ({vram_sel_o, vram_wr_o, busy_o, full_o, done_o, vram_addr_o, vram_mask_o}
                === 25'd0) else begin
            $display("Mismatch reset_state: expected all zero, actual %b %b %b %b %b %h %h",
                     vram_sel_o, vram_wr_o, busy_o, full_o, done_o, vram_addr_o, vram_mask_o);
            fail_run();
        end
    endtask

    initial begin
        wait (timeout_ns > 0);
        #(timeout_ns);
        $display("Timeout: the blitter did not finish all jobs in time");
        fail_run();
    end

    initial begin
        int k;
        int kind;
        int accesses;
        int total_lines;
        int base;
        reset_i     = 1'b1;
        reg_wr_i    = 1'b0;
        reg_num_i   = 4'd0;
        reg_data_i  = 16'h0000;
        vram_ack_i  = 1'b0;
        vram_data_i = 16'h0000;
        accesses    = 0;
        total_lines = 0;
        for (k = 0; k < 10; k++) begin
            kind         = (k < 2) ? 0 : (k < 5) ? 1 : (k < 8) ? 2 : 3;
            jobs[k]      = gen_job(kind);
            test_name[k] = (kind == 0) ? "const_fill" : (kind == 1) ? "shift_copy" :
                           (kind == 2) ? "logic_transp" : "queue";
            accesses     = accesses + (jobs[k].lines + 1) * (jobs[k].words + 1)
                           * (jobs[k].b_const ? 1 : 2);
            total_lines  = total_lines + jobs[k].lines + 1;
        end
        timeout_ns = (accesses * 8 + total_lines * 4 + 2000) * 4;
        for (k = 0; k < 4096; k++) begin
            vram[k]  = k * 16'h9e37 + 16'h5a5a;    // odd multiplier, distinct per address
            model[k] = vram[k];
        end

        repeat (10) begin
            @(negedge clk);
            check_idle();
        end
        reset_i = 1'b0;
        repeat (5) begin
            @(negedge clk);
            check_idle();
        end

        for (k = 0; k < 8; k++) begin
            full_mask_check = (k < 2);
            base = done_cnt;
            load_job(jobs[k]);
            while (done_cnt == base) begin
                @(negedge clk);
            end
            apply_model(jobs[k]);
            compare_mem(test_name[k]);
        end

        // second job written while the first one runs
        full_mask_check = 1'b0;
        base = done_cnt;
        load_job(jobs[8]);
        while (!busy_o) begin
            @(negedge clk);
        end
        load_job(jobs[9]);
        assert (full_o === 1'b1 && busy_o === 1'b1) else begin
            $display("Mismatch queue full: expected 1, actual %b", full_o);
            fail_run();
        end
        while (done_cnt < base + 2) begin
            assert (busy_o === 1'b1 || (done_o === 1'b1 && done_cnt == base + 1)) else begin
                $display("Sequencer returned to idle between the two queued jobs");
                fail_run();
            end
            @(negedge clk);
        end
        repeat (20) begin
            @(negedge clk);
        end
        assert (done_cnt == base + 2) else begin
            $display("Mismatch queue done pulses: expected 2, actual %0d", done_cnt - base);
            fail_run();
        end
        apply_model(jobs[8]);
        apply_model(jobs[9]);
        compare_mem("queue");

        if (error_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            fail_run();
        end
    end

endmodule
